// ==== Makefile ====
# Verilator build and run of the predecode testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run predecTb, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module predecTb -f list.f --Mdir obj_dir -o predecSim
	./obj_dir/predecSim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
verilog/predecPkg.sv
verilog/opLenDecode.sv
verilog/boundaryScan.sv
verilog/resultFifo.sv
verilog/axiLiteRegs.sv
verilog/predecTop.sv
tb/predecTb.sv

// ==== tb/predecTb.sv ====
// ==============================
// Testbench for the predecode subsystem
// Reads tb/predecTests.txt, so run from the project root
// Stops at the first mismatch
// Result reads with expected valid 0 compare bit 31 only
// ==============================

`timescale 1ns/1ps

module predecTb
	import predecPkg::*;
();

	logic clk;
	logic rstN;
	logic [3:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [3:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	byte cmdQ[$];
	logic [31:0] argQ[$];
	logic [31:0] expQ[$];
	int cycleLimit;
	int cycles;

	predecTop u_predecTop (
		.clk, .rstN, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
		.rvalid, .rready
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// Register map is mode 0x0, parcel 0x4, result 0x8
	function automatic logic [1:0] expectResp(input logic [3:0] addr);
		case (addr)
			4'h0, 4'h4, 4'h8: return 2'b00;
			default: return 2'b10;
		endcase
	endfunction

	task automatic stopRun();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
		else
		begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			stopRun();
		end
	endtask

	task automatic checkResult(input logic [3:0] addr, input logic [31:0] exp,
		input logic [31:0] got);
		if ((addr == addrResult) && !exp[31])
			checkWord("rdata valid", 32'(exp[31]), 32'(got[31])); // Stale head fields
		else
			checkWord("rdata", exp, got);
	endtask

	task automatic startWrite(input logic [3:0] addr, input logic [31:0] data);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
	endtask

	task automatic finishWrite(input logic [3:0] addr);
		logic accepted;
		accepted = 1'b0;
		while (!accepted)
		begin
			#1;
			accepted = awready && wready; // Settled inside the low phase
			@(negedge clk);
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk);
		checkWord("bresp", 32'(expectResp(addr)), 32'(bresp));
	endtask

	task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
		startWrite(addr, data);
		finishWrite(addr);
	endtask

	task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
		logic accepted;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		accepted = 1'b0;
		while (!accepted)
		begin
			#1;
			accepted = arready;
			@(negedge clk);
		end
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		checkWord("rresp", 32'(expectResp(addr)), 32'(rresp));
	endtask

	// Parcel write against a full queue, one read must release it
	task automatic heldWrite(input logic [31:0] data, input logic [31:0] exp);
		logic [31:0] got;
		startWrite(addrParcel, data);
		repeat (4)
		begin
			#1;
			assert (!awready && !wready)
			else
			begin
				$display("A parcel write was accepted while the result queue was full");
				stopRun();
			end
			@(negedge clk);
		end
		axiRead(addrResult, got);
		checkResult(addrResult, exp, got);
		finishWrite(addrParcel);
	endtask

	initial
	begin
		int fd;
		int n;
		string line;
		byte cmd;
		logic [31:0] arg;
		logic [31:0] exp;
		logic [31:0] got;
		rstN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b1; // Responses always taken at once
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		fd = $fopen("tb/predecTests.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test file tb/predecTests.txt");
			stopRun();
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if ((n > 0) && ($sscanf(line, "%c %h %h", cmd, arg, exp) == 3) && (cmd != "#"))
			begin
				cmdQ.push_back(cmd);
				argQ.push_back(arg);
				expQ.push_back(exp);
			end
		end
		$fclose(fd);
		cycleLimit = cmdQ.size() * 16 + 100;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		foreach (cmdQ[i])
		begin
			case (cmdQ[i])
				"M": axiWrite(addrMode, argQ[i]);
				"P": axiWrite(addrParcel, argQ[i]);
				"W": axiWrite(argQ[i][3:0], expQ[i]); // Raw write to any offset
				"S": heldWrite(argQ[i], expQ[i]);
				"R":
				begin
					axiRead(argQ[i][3:0], got);
					checkResult(argQ[i][3:0], expQ[i], got);
				end
				default:
				begin
					$display("Unknown command in test entry %0d", i);
					stopRun();
				end
			endcase
		end
		$display("RESULT: PASS");
		$finish;
	end

	initial
	begin
		cycles = 0;
		@(posedge rstN);
		forever
		begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycles > cycleLimit)
			begin
				$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
				stopRun();
			end
		end
	end

endmodule

// ==== tb/predecTests.txt ====
# cmd arg exp: M mode write, P parcel write, W raw write (arg addr, exp data)
# S held parcel write released by a result read (exp), R read (arg addr, exp word)
M 0 0
P 1234 0
P F000 0
P 0000 0
P FE00 0
P 5555 0
P E800 0
P AAAA 0
P 9800 0
P 0000 0
P 7000 0
P 0000 0
P 2345 0
P 3456 0
S 4567 81000001
R 8 82000100
R 8 8200030E
R 8 82000500
R 8 82000704
R 8 82000900
R 8 81000B01
R 8 81000C01
R 8 81000D01
R 8 00000000
M 2 0
P 0001 0
P 003F 0
P 0000 0
P 401B 0
P 0000 0
P 007F 0
P 0000 0
P 0000 0
P 0000 0
P 0000 0
P 0000 0
P 0001 0
R 8 81000001
R 8 8200010E
R 8 8200030E
R 8 8600050F
R 8 81000B01
P 603F 0
R 8 86000C0F
M 2 0
P 0001 0
R 8 81000001
R 0 00000002
M 6 0
P 0001 0
P 0000 0
P 001A 0
R 8 82000000
R 8 8200020E
M 1 0
P 1234 0
P 0000 0
P 0E00 0
R 8 82000000
R 8 82000204
M 5 0
P 0E00 0
R 8 82000006
R 0 00000005
W C 7
R 0 00000005
R C 00000000

// ==== verilog/axiLiteRegs.sv ====
// ==============================
// AXI4-Lite slave with combinational ready
// Ready rises only when both address and data are valid
// Parcel writes wait while the scanner stalls
// No write strobes, no protection bits
// ==============================

`timescale 1ns/1ps

module axiLiteRegs
	import predecPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic stall,
	input instRecT head,
	input logic empty,
	output modeT mode,
	output logic modeWrite,
	output parcelT parcel,
	output logic parcelValid,
	output logic pop
);

	axiWrStateE wrState;
	axiRdStateE rdState;
	logic wrAccept;
	logic rdAccept;
	logic wrKnown;
	logic rdKnown;
	logic [15:0] parcelIdx;
	logic [31:0] rdWord;

	assign wrKnown = awaddr inside {addrMode, addrParcel, addrResult};
	assign rdKnown = araddr inside {addrMode, addrParcel, addrResult};

	assign wrAccept = (wrState == wrIdle) && awvalid && wvalid
		&& !((awaddr == addrParcel) && stall);
	assign awready = wrAccept;
	assign wready = wrAccept;

	assign modeWrite = wrAccept && (awaddr == addrMode);
	assign parcelValid = wrAccept && (awaddr == addrParcel);
	assign parcel = '{bits: wdata[15:0], index: parcelIdx};

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			mode <= '0;
			parcelIdx <= '0;
		end
		else if (modeWrite)
		begin
			mode <= modeT'(wdata[2:0]);
			parcelIdx <= '0; // Numbering restarts with each mode
		end
		else if (parcelValid)
			parcelIdx <= parcelIdx + 16'd1;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrState <= wrIdle;
			bvalid <= 1'b0;
			bresp <= respOkay;
		end
		else
		begin
			case (wrState)
				wrIdle:
					if (wrAccept)
					begin
						wrState <= wrResp;
						bvalid <= 1'b1;
						bresp <= wrKnown ? respOkay : respSlvErr;
					end
				wrResp:
					if (bready)
					begin
						wrState <= wrIdle;
						bvalid <= 1'b0;
					end
				default: wrState <= wrIdle;
			endcase
		end
	end

	assign rdAccept = (rdState == rdIdle) && arvalid;
	assign arready = rdAccept;
	assign pop = rdAccept && (araddr == addrResult) && !empty; // Empty reads do not pop

	always_comb
	begin
		case (araddr)
			addrMode: rdWord = {29'd0, mode};
			addrResult: rdWord = {!empty, 4'd0, head.parcels, head.startIndex, 4'd0, head.opLen};
			default: rdWord = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rdAccept)
		begin
			rdata <= rdWord; // Head sampled before the pop lands
			rresp <= rdKnown ? respOkay : respSlvErr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			rdState <= rdIdle;
			rvalid <= 1'b0;
		end
		else if (rdAccept)
		begin
			rdState <= rdData;
			rvalid <= 1'b1;
		end
		else if (rvalid && rready)
		begin
			rdState <= rdIdle;
			rvalid <= 1'b0;
		end
	end

	bHoldA: assert property (@(posedge clk) disable iff (!rstN) bvalid && !bready |=> bvalid);
	rHoldA: assert property (@(posedge clk) disable iff (!rstN) rvalid && !rready |=> rvalid);

endmodule

// ==== verilog/boundaryScan.sv ====
// ==============================
// Splits the parcel stream into instructions
// Only start parcels are decoded, continuations are counted off
// Record and push are combinational from the accepted parcel
// Stall follows queue full
// ==============================

`timescale 1ns/1ps

module boundaryScan
	import predecPkg::*;
(
	input logic clk,
	input logic rstN,
	input parcelT parcel,
	input logic parcelValid,
	input modeT mode,
	input logic modeWrite,
	input logic full,
	output logic stall,
	output instRecT rec,
	output logic push
);

	opLenT opLen;
	logic [2:0] nParcels;
	logic [2:0] skipCnt;
	logic isStart;

	opLenDecode u_opLenDecode (
		.istrBits(parcel.bits),
		.mode(mode),
		.opLen(opLen)
	);

	always_comb
	begin
		case (opLen)
			4'b1111: nParcels = 3'd6; // 96-bit form
			4'b0001: nParcels = 3'd1;
			default: nParcels = 3'd2;
		endcase
	end

	assign isStart = (skipCnt == 3'd0);
	assign stall = full;
	assign push = parcelValid && isStart;
	assign rec = '{startIndex: parcel.index, opLen: opLen, parcels: nParcels}; // Index tagged by slave

	always_ff @(posedge clk)
	begin
		if (!rstN || modeWrite)
			skipCnt <= '0;
		else if (parcelValid)
			skipCnt <= isStart ? nParcels - 3'd1 : skipCnt - 3'd1;
	end

	noStallA: assert property (@(posedge clk) disable iff (!rstN) parcelValid |-> !stall);

endmodule

// ==== verilog/opLenDecode.sv ====
// ==============================
// Op-length classifier for a single 16-bit parcel
// RISC-V, RV jumbo and XG3 forms enabled, RV 48-bit form absent
// Purely combinational
// ==============================

`timescale 1ns/1ps

module opLenDecode
	import predecPkg::*;
(
	input logic [15:0] istrBits,
	input modeT mode,
	output opLenT opLen
);

	opLenT lenRaw;
	logic isXG3;

	assign isXG3 = mode.isRV && mode.isWXE;

	always_comb
	begin
		casez ({mode.isXG2, istrBits[15:9]})
			8'b1_???1_111: lenRaw = 4'b1110; // Jumbo prefix
			8'b1_???1_110: lenRaw = 4'b0110;
			8'b1_???1_10?: lenRaw = 4'b0010;
			8'b1_???1_01?: lenRaw = 4'b0110;
			8'b1_???1_00?: lenRaw = 4'b0010;
			8'b1_???0_111: lenRaw = 4'b0110;
			8'b1_???0_110: lenRaw = 4'b0010;
			8'b1_???0_101: lenRaw = 4'b0110;
			8'b1_???0_100: lenRaw = 4'b0010;
			8'b1_???0_0??: lenRaw = 4'b0010;

			8'b0_1111_111: lenRaw = 4'b1110; // FE/FF
			8'b0_1111_110: lenRaw = 4'b0110;
			8'b0_1111_10?: lenRaw = 4'b0010;
			8'b0_1111_01?: lenRaw = 4'b0110;
			8'b0_1111_00?: lenRaw = 4'b0010;
			8'b0_1110_111: lenRaw = 4'b0110;
			8'b0_1110_110: lenRaw = 4'b0010;
			8'b0_1110_101: lenRaw = 4'b0110;
			8'b0_1110_100: lenRaw = 4'b0010;
			8'b0_1110_0??: lenRaw = 4'b0010;

			8'b0_1001_1??: lenRaw = 4'b0110;
			8'b0_1001_0??: lenRaw = 4'b0010;
			8'b0_0111_1??: lenRaw = 4'b0110;
			8'b0_0111_0??: lenRaw = 4'b0010;

			default: lenRaw = 4'b0001; // Plain 16-bit op
		endcase

		// Later matches override earlier ones
		if (mode.isRV)
		begin
			lenRaw = 4'b0010;
			if ((istrBits[1:0] != 2'b11) && !isXG3)
				lenRaw = 4'b0001; // Compressed
			if ((istrBits[6:0] == 7'h1B) && (istrBits[14:12] == 3'h4))
				lenRaw = 4'b1110; // RV jumbo
			if (istrBits[6:0] == 7'h3F)
				lenRaw = (istrBits[14:13] == 2'b11) ? 4'b1111 : 4'b1110;
			if (istrBits[6:0] == 7'h7F)
				lenRaw = 4'b1111; // Taken as 96 bits
			if ((istrBits[4:3] == 2'b11) && (istrBits[1:0] == 2'b10) && isXG3)
				lenRaw = 4'b1110;
		end
	end

	// Bit 1 rebuilt from jumbo and WEX under WXE
	assign opLen = {lenRaw[3:2], lenRaw[3] | (lenRaw[2] & mode.isWXE), lenRaw[0]};

endmodule

// ==== verilog/predecPkg.sv ====
// ==============================
// Shared types for the predecode subsystem
// Register offsets are 4-bit byte addresses, full-word access only
// fifoDepth must stay a power of two so that the pointers wrap by themselves
// ==============================

package predecPkg;

	localparam int fifoDepth = 8; // Records held by the result queue
	localparam int ptrW = $clog2(fifoDepth);
	localparam int cntW = $clog2(fifoDepth + 1);

	localparam logic [3:0] addrMode = 4'h0;
	localparam logic [3:0] addrParcel = 4'h4;
	localparam logic [3:0] addrResult = 4'h8;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// Bit 3 jumbo, bit 2 WEX, bit 1 jumbo or WEX under WXE, bit 0 16/48
	typedef logic [3:0] opLenT;

	typedef struct packed {
		logic isWXE; // wdata[2]
		logic isRV; // wdata[1]
		logic isXG2; // wdata[0]
	} modeT;

	typedef struct packed {
		logic [15:0] bits;
		logic [15:0] index; // Parcel number since last mode write
	} parcelT;

	typedef struct packed {
		logic [15:0] startIndex;
		opLenT opLen;
		logic [2:0] parcels;
	} instRecT;

	typedef enum logic {wrIdle, wrResp} axiWrStateE;
	typedef enum logic {rdIdle, rdData} axiRdStateE;

endpackage

// ==== verilog/predecTop.sv ====
// ==============================
// Predecode subsystem top
// 32-bit AXI4-Lite data, 4-bit address
// ==============================

`timescale 1ns/1ps

module predecTop
	import predecPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	modeT mode;
	parcelT parcel;
	instRecT rec;
	instRecT head;
	logic modeWrite, parcelValid, stall, push, pop, empty, full;

	axiLiteRegs u_axiLiteRegs (
		.clk, .rstN, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
		.rvalid, .rready, .stall, .head, .empty, .mode, .modeWrite, .parcel,
		.parcelValid, .pop
	);

	boundaryScan u_boundaryScan (
		.clk, .rstN, .parcel, .parcelValid, .mode, .modeWrite, .full, .stall, .rec, .push
	);

	resultFifo u_resultFifo (
		.clk, .rstN, .rec, .push, .pop, .head, .empty, .full
	);

endmodule

// ==== verilog/resultFifo.sv ====
// ==============================
// Circular queue of instruction records
// Push and pop may share a cycle
// Head is valid only while not empty
// ==============================

`timescale 1ns/1ps

module resultFifo
	import predecPkg::*;
(
	input logic clk,
	input logic rstN,
	input instRecT rec,
	input logic push,
	input logic pop,
	output instRecT head,
	output logic empty,
	output logic full
);

	instRecT mem [fifoDepth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;

	assign head = mem[rdPtr];
	assign empty = (count == '0);
	assign full = (count == cntW'(fifoDepth));

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= rec;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			wrPtr <= wrPtr + ptrW'(push); // Wraps at fifoDepth
			rdPtr <= rdPtr + ptrW'(pop);
			count <= count + cntW'(push) - cntW'(pop);
		end
	end

	noOverA: assert property (@(posedge clk) disable iff (!rstN) push |-> !full);
	noUnderA: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty);

endmodule
